/* compile.f */
+incdir+tests
verilog/l2_pkg.sv
verilog/l2_msg_fifo.sv
verilog/l2_line_store.sv
verilog/l2_ctrl.sv
verilog/l2_wrapper.sv
tests/l2_wrapper_tb.sv

/* Bender.yml */
package:
  name: l2_cache

sources:
  - files:
      - verilog/l2_pkg.sv
      - verilog/l2_msg_fifo.sv
      - verilog/l2_line_store.sv
      - verilog/l2_ctrl.sv
      - verilog/l2_wrapper.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/l2_wrapper_tb.sv

/* tests/l2_model.svh */
`ifndef L2_MODEL_SVH
`define L2_MODEL_SVH

// the 64 test lines share the upper address bits, the low 6 bits pick the line
localparam line_addr_t LINE_BASE = 28'h0abcd00;

line_t home_mem [64];
l2_state_t line_state [64];
line_t line_data [64];

l2_req_out_t exp_req [$];
l2_rsp_out_t exp_rsp [$];
line_addr_t exp_inval [$];
line_t exp_rd [$];

function automatic logic [31:0] xorshift32(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

function automatic line_addr_t line_of(logic [5:0] k);
    return {LINE_BASE[27:6], k};
endfunction

function automatic line_t fill_pattern(line_addr_t a);
    line_t l;
    for (int j = 0; j < 4; j++) begin
        l[j*32 +: 32] = {a, 2'(j), 2'b00} ^ 32'h3c5a_0000;
    end
    return l;
endfunction

task automatic reset_model();
    for (int k = 0; k < 64; k++) begin
        home_mem[k] = fill_pattern(line_of(6'(k)));
        line_state[k] = INVALID;
        line_data[k] = '0;
    end
endtask

// any other alias holding the set leaves first
task automatic drop_victim(logic [5:0] k, hprot_t hprot);
    logic [5:0] v;
    for (int a = 0; a < 4; a++) begin
        v = {2'(a), k[3:0]};
        if (v != k && line_state[v] == MODIFIED) begin
            exp_req.push_back(l2_req_out_t'{REQ_PUTM, hprot, line_of(v), line_data[v]});
        end
        if (v != k && line_state[v] != INVALID) begin
            exp_inval.push_back(line_of(v));
            line_state[v] = INVALID;
        end
    end
endtask

task automatic apply_cpu_access(cpu_msg_t op, hprot_t hprot, logic [5:0] k,
                                logic [1:0] w, word_t data);
    if (op == READ) begin
        if (line_state[k] == INVALID) begin
            drop_victim(k, hprot);
            exp_req.push_back(l2_req_out_t'{REQ_GETS, hprot, line_of(k), '0});
            line_data[k] = home_mem[k];
            line_state[k] = SHARED;
        end
        exp_rd.push_back(line_data[k]);
    end else begin
        if (line_state[k] != MODIFIED) begin
            if (line_state[k] == INVALID) begin
                drop_victim(k, hprot);
            end
            exp_req.push_back(l2_req_out_t'{REQ_GETM, hprot, line_of(k), '0});
            line_data[k] = home_mem[k];
            line_state[k] = MODIFIED;
        end
        line_data[k][w*32 +: 32] = data;
    end
endtask

task automatic handle_forward(mix_msg_t f, logic [5:0] k, cache_id_t id);
    if (f == FWD_INV) begin
        exp_rsp.push_back(l2_rsp_out_t'{RSP_INVACK, id, 2'b01, line_of(k), '0});
        if (line_state[k] != INVALID) begin
            exp_inval.push_back(line_of(k));
        end
        line_state[k] = INVALID;
    end else if (line_state[k] == MODIFIED) begin
        if (f == FWD_GETS) begin
            exp_rsp.push_back(l2_rsp_out_t'{RSP_DATA, id, 2'b11, line_of(k), line_data[k]});
            line_state[k] = SHARED;
        end else begin
            exp_rsp.push_back(l2_rsp_out_t'{RSP_DATA, id, 2'b01, line_of(k), line_data[k]});
            exp_inval.push_back(line_of(k));
            line_state[k] = INVALID;
        end
    end
endtask

`endif

/* tests/l2_wrapper_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module l2_wrapper_tb;

    import l2_pkg::*;

    localparam int CLK_PERIOD = 10;
    localparam int N_OPS = 2000;
    localparam logic [31:0] SEED = 32'd46178;

    logic clk;
    logic reset;
    logic l2_cpu_req_valid;
    cpu_msg_t l2_cpu_req_data_cpu_msg;
    hprot_t l2_cpu_req_data_hprot;
    addr_t l2_cpu_req_data_addr;
    word_t l2_cpu_req_data_word;
    logic l2_cpu_req_ready;
    logic l2_fwd_in_valid;
    mix_msg_t l2_fwd_in_data_coh_msg;
    line_addr_t l2_fwd_in_data_addr;
    cache_id_t l2_fwd_in_data_req_id;
    logic l2_fwd_in_ready;
    logic l2_rsp_in_valid;
    coh_msg_t l2_rsp_in_data_coh_msg;
    line_addr_t l2_rsp_in_data_addr;
    line_t l2_rsp_in_data_line;
    logic l2_rsp_in_ready;
    logic l2_rd_rsp_valid;
    line_t l2_rd_rsp_data_line;
    logic l2_rd_rsp_ready;
    logic l2_inval_valid;
    line_addr_t l2_inval_data;
    logic l2_inval_ready;
    logic l2_req_out_valid;
    coh_msg_t l2_req_out_data_coh_msg;
    hprot_t l2_req_out_data_hprot;
    line_addr_t l2_req_out_data_addr;
    line_t l2_req_out_data_line;
    logic l2_req_out_ready;
    logic l2_rsp_out_valid;
    coh_msg_t l2_rsp_out_data_coh_msg;
    cache_id_t l2_rsp_out_data_req_id;
    to_req_t l2_rsp_out_data_to_req;
    line_addr_t l2_rsp_out_data_addr;
    line_t l2_rsp_out_data_line;
    logic l2_rsp_out_ready;

    `include "l2_model.svh"

    l2_req_out_t req_seen;
    l2_rsp_out_t rsp_seen;
    l2_req_out_t home_q [$];
    int home_open;
    logic rsp_in_fired;
    logic [31:0] stim_rng;
    logic [31:0] stall_rng;

    assign req_seen = {l2_req_out_data_coh_msg, l2_req_out_data_hprot,
                       l2_req_out_data_addr, l2_req_out_data_line};
    assign rsp_seen = {l2_rsp_out_data_coh_msg, l2_rsp_out_data_req_id,
                       l2_rsp_out_data_to_req, l2_rsp_out_data_addr, l2_rsp_out_data_line};

    l2_wrapper #(
        .SETS(16),
        .FIFO_DEPTH(2)
    ) l2_wrapper_i (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic fail_run(string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_value(string name, logic [191:0] expected, logic [191:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
            $display("Test failed");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    task automatic answer_home(l2_req_out_t m);
        l2_rsp_in_data_addr = m.addr;
        if (m.coh_msg == REQ_PUTM) begin
            home_mem[m.addr[5:0]] = m.line;
            l2_rsp_in_data_coh_msg = RSP_PUTACK;
            l2_rsp_in_data_line = '0;
        end else begin
            l2_rsp_in_data_coh_msg = RSP_DATA;
            l2_rsp_in_data_line = home_mem[m.addr[5:0]];
        end
        l2_rsp_in_valid = 1'b1;
    endtask

    // transfers are seen mid cycle and complete on the next rising edge
    always @(negedge clk) begin
        if (!reset) begin
            if (l2_req_out_valid && l2_req_out_ready) begin
                if (exp_req.size() == 0) begin
                    fail_run("req_out carried a message that was not expected");
                end else begin
                    check_value("req_out", exp_req.pop_front(), req_seen);
                    home_q.push_back(req_seen);
                    home_open++;
                end
            end
            if (l2_rsp_out_valid && l2_rsp_out_ready) begin
                if (exp_rsp.size() == 0) begin
                    fail_run("rsp_out carried a message that was not expected");
                end else begin
                    check_value("rsp_out", exp_rsp.pop_front(), rsp_seen);
                    // a copy sent to the home updates memory
                    if (rsp_seen.to_req[1]) begin
                        home_mem[rsp_seen.addr[5:0]] = rsp_seen.line;
                    end
                end
            end
            if (l2_inval_valid && l2_inval_ready) begin
                if (exp_inval.size() == 0) begin
                    fail_run("inval reported a line that was not expected");
                end else begin
                    check_value("inval", exp_inval.pop_front(), l2_inval_data);
                end
            end
            if (l2_rd_rsp_valid && l2_rd_rsp_ready) begin
                if (exp_rd.size() == 0) begin
                    fail_run("rd_rsp returned data that was not expected");
                end else begin
                    check_value("rd_rsp", exp_rd.pop_front(), l2_rd_rsp_data_line);
                end
            end
            if (l2_rsp_in_valid && l2_rsp_in_ready) begin
                rsp_in_fired = 1'b1;
                home_open--;
            end
        end
    end

    // home responder and random output stalls
    always begin
        @(posedge clk);
        #1;
        if (rsp_in_fired) begin
            l2_rsp_in_valid = 1'b0;
            rsp_in_fired = 1'b0;
        end
        stall_rng = xorshift32(stall_rng);
        if (!reset && !l2_rsp_in_valid && home_q.size() != 0 && stall_rng[0]) begin
            answer_home(home_q.pop_front());
        end
        l2_rd_rsp_ready = stall_rng[3:2] != 2'b00;
        l2_inval_ready = stall_rng[5:4] != 2'b00;
        l2_req_out_ready = stall_rng[7:6] != 2'b00;
        l2_rsp_out_ready = stall_rng[9:8] != 2'b00;
    end

    task automatic wait_idle();
        do begin
            @(posedge clk);
            #1;
        end while (exp_req.size() != 0 || exp_rsp.size() != 0 || exp_inval.size() != 0 ||
                   exp_rd.size() != 0 || home_open != 0 || !l2_cpu_req_ready);
        // nothing may be left on an output once every expected message is out
        check_value("outputs quiet when idle", 4'b0000,
                    {l2_rd_rsp_valid, l2_inval_valid, l2_req_out_valid, l2_rsp_out_valid});
    endtask

    task automatic run_one_op();
        logic [31:0] r;
        logic [5:0] k;
        logic [1:0] w;
        word_t data;
        mix_msg_t fwd;
        cpu_msg_t op;
        stim_rng = xorshift32(stim_rng);
        r = stim_rng;
        stim_rng = xorshift32(stim_rng);
        data = stim_rng;
        k = r[13:8];
        w = r[15:14];
        if (r[3:0] < 4'd3) begin
            fwd = mix_msg_t'(r[20:19] == 2'd3 ? 2'd0 : r[20:19]);
            handle_forward(fwd, k, r[18:17]);
            l2_fwd_in_data_coh_msg = fwd;
            l2_fwd_in_data_addr = line_of(k);
            l2_fwd_in_data_req_id = r[18:17];
            l2_fwd_in_valid = 1'b1;
            do begin
                @(negedge clk);
            end while (!l2_fwd_in_ready);
            @(posedge clk);
            #1;
            l2_fwd_in_valid = 1'b0;
        end else begin
            op = r[4] ? READ : WRITE;
            apply_cpu_access(op, r[16], k, w, data);
            l2_cpu_req_data_cpu_msg = op;
            l2_cpu_req_data_hprot = r[16];
            l2_cpu_req_data_addr = {line_of(k), w, 2'b00};
            l2_cpu_req_data_word = data;
            l2_cpu_req_valid = 1'b1;
            do begin
                @(negedge clk);
            end while (!l2_cpu_req_ready);
            @(posedge clk);
            #1;
            l2_cpu_req_valid = 1'b0;
        end
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        l2_cpu_req_valid = 1'b0;
        l2_cpu_req_data_cpu_msg = READ;
        l2_cpu_req_data_hprot = '0;
        l2_cpu_req_data_addr = '0;
        l2_cpu_req_data_word = '0;
        l2_fwd_in_valid = 1'b0;
        l2_fwd_in_data_coh_msg = FWD_INV;
        l2_fwd_in_data_addr = '0;
        l2_fwd_in_data_req_id = '0;
        l2_rsp_in_valid = 1'b0;
        l2_rsp_in_data_coh_msg = RSP_DATA;
        l2_rsp_in_data_addr = '0;
        l2_rsp_in_data_line = '0;
        l2_rd_rsp_ready = 1'b1;
        l2_inval_ready = 1'b1;
        l2_req_out_ready = 1'b1;
        l2_rsp_out_ready = 1'b1;
        home_open = 0;
        rsp_in_fired = 1'b0;
        stim_rng = SEED;
        stall_rng = xorshift32(SEED ^ 32'h9e37_79b9);
        reset_model();
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        check_value("valids after reset", 4'b0000,
                    {l2_rd_rsp_valid, l2_inval_valid, l2_req_out_valid, l2_rsp_out_valid});
        check_value("readies during sweep", 3'b000,
                    {l2_cpu_req_ready, l2_fwd_in_ready, l2_rsp_in_ready});
        for (int n = 0; n < N_OPS; n++) begin
            wait_idle();
            run_one_op();
        end
        wait_idle();
        $display("Test passed");
        $finish;
    end

    // 200 cycles per operation
    initial begin
        #(N_OPS * 200 * CLK_PERIOD);
        $display("watchdog expired, the DUT stopped making progress");
        $display("Test failed");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

/* verilog/l2_wrapper.sv */
`timescale 1ns/1ps
`default_nettype none

module l2_wrapper #(
    parameter int SETS = 16,
    parameter int FIFO_DEPTH = 2
) (
    input  wire logic                clk,
    input  wire logic                reset,

    input  wire logic                l2_cpu_req_valid,
    input  wire l2_pkg::cpu_msg_t    l2_cpu_req_data_cpu_msg,
    input  wire l2_pkg::hprot_t      l2_cpu_req_data_hprot,
    input  wire l2_pkg::addr_t       l2_cpu_req_data_addr,
    input  wire l2_pkg::word_t       l2_cpu_req_data_word,
    output logic                     l2_cpu_req_ready,

    input  wire logic                l2_fwd_in_valid,
    input  wire l2_pkg::mix_msg_t    l2_fwd_in_data_coh_msg,
    input  wire l2_pkg::line_addr_t  l2_fwd_in_data_addr,
    input  wire l2_pkg::cache_id_t   l2_fwd_in_data_req_id,
    output logic                     l2_fwd_in_ready,

    input  wire logic                l2_rsp_in_valid,
    input  wire l2_pkg::coh_msg_t    l2_rsp_in_data_coh_msg,
    input  wire l2_pkg::line_addr_t  l2_rsp_in_data_addr,
    input  wire l2_pkg::line_t       l2_rsp_in_data_line,
    output logic                     l2_rsp_in_ready,

    output logic                     l2_rd_rsp_valid,
    output l2_pkg::line_t            l2_rd_rsp_data_line,
    input  wire logic                l2_rd_rsp_ready,

    output logic                     l2_inval_valid,
    output l2_pkg::line_addr_t       l2_inval_data,
    input  wire logic                l2_inval_ready,

    output logic                     l2_req_out_valid,
    output l2_pkg::coh_msg_t         l2_req_out_data_coh_msg,
    output l2_pkg::hprot_t           l2_req_out_data_hprot,
    output l2_pkg::line_addr_t       l2_req_out_data_addr,
    output l2_pkg::line_t            l2_req_out_data_line,
    input  wire logic                l2_req_out_ready,

    output logic                     l2_rsp_out_valid,
    output l2_pkg::coh_msg_t         l2_rsp_out_data_coh_msg,
    output l2_pkg::cache_id_t        l2_rsp_out_data_req_id,
    output l2_pkg::to_req_t          l2_rsp_out_data_to_req,
    output l2_pkg::line_addr_t       l2_rsp_out_data_addr,
    output l2_pkg::line_t            l2_rsp_out_data_line,
    input  wire logic                l2_rsp_out_ready
);

    import l2_pkg::*;

    l2_cpu_req_t cpu_req;
    l2_fwd_in_t fwd_in;
    l2_rsp_in_t rsp_in;
    l2_req_out_t req_msg;
    l2_req_out_t req_out;
    l2_rsp_out_t rsp_msg;
    l2_rsp_out_t rsp_out;
    logic req_push;
    logic req_full;
    logic rsp_push;
    logic rsp_full;
    logic [$clog2(SETS)-1:0] rd_index;
    logic [$clog2(SETS)-1:0] wr_index;
    logic wr_en;
    l2_line_entry_t rd_entry;
    l2_line_entry_t wr_entry;

    assign cpu_req.cpu_msg = l2_cpu_req_data_cpu_msg;
    assign cpu_req.hprot = l2_cpu_req_data_hprot;
    assign cpu_req.addr = l2_cpu_req_data_addr;
    assign cpu_req.word = l2_cpu_req_data_word;

    assign fwd_in.coh_msg = l2_fwd_in_data_coh_msg;
    assign fwd_in.addr = l2_fwd_in_data_addr;
    assign fwd_in.req_id = l2_fwd_in_data_req_id;

    assign rsp_in.coh_msg = l2_rsp_in_data_coh_msg;
    assign rsp_in.addr = l2_rsp_in_data_addr;
    assign rsp_in.line = l2_rsp_in_data_line;

    assign l2_req_out_data_coh_msg = req_out.coh_msg;
    assign l2_req_out_data_hprot = req_out.hprot;
    assign l2_req_out_data_addr = req_out.addr;
    assign l2_req_out_data_line = req_out.line;

    assign l2_rsp_out_data_coh_msg = rsp_out.coh_msg;
    assign l2_rsp_out_data_req_id = rsp_out.req_id;
    assign l2_rsp_out_data_to_req = rsp_out.to_req;
    assign l2_rsp_out_data_addr = rsp_out.addr;
    assign l2_rsp_out_data_line = rsp_out.line;

    l2_ctrl #(
        .SETS(SETS)
    ) ctrl_i (
        .clk(clk),
        .reset(reset),
        .cpu_req_valid(l2_cpu_req_valid),
        .cpu_req(cpu_req),
        .cpu_req_ready(l2_cpu_req_ready),
        .fwd_in_valid(l2_fwd_in_valid),
        .fwd_in(fwd_in),
        .fwd_in_ready(l2_fwd_in_ready),
        .rsp_in_valid(l2_rsp_in_valid),
        .rsp_in(rsp_in),
        .rsp_in_ready(l2_rsp_in_ready),
        .rd_rsp_valid(l2_rd_rsp_valid),
        .rd_rsp_line(l2_rd_rsp_data_line),
        .rd_rsp_ready(l2_rd_rsp_ready),
        .inval_valid(l2_inval_valid),
        .inval_addr(l2_inval_data),
        .inval_ready(l2_inval_ready),
        .req_push(req_push),
        .req_msg(req_msg),
        .req_full(req_full),
        .rsp_push(rsp_push),
        .rsp_msg(rsp_msg),
        .rsp_full(rsp_full),
        .rd_index(rd_index),
        .rd_entry(rd_entry),
        .wr_en(wr_en),
        .wr_index(wr_index),
        .wr_entry(wr_entry)
    );

    l2_line_store #(
        .SETS(SETS)
    ) store_i (
        .clk(clk),
        .reset(reset),
        .rd_index(rd_index),
        .rd_entry(rd_entry),
        .wr_en(wr_en),
        .wr_index(wr_index),
        .wr_entry(wr_entry)
    );

    l2_msg_fifo #(
        .DEPTH(FIFO_DEPTH),
        .T(l2_req_out_t)
    ) req_fifo (
        .clk(clk),
        .reset(reset),
        .push(req_push),
        .push_data(req_msg),
        .full(req_full),
        .valid(l2_req_out_valid),
        .data(req_out),
        .ready(l2_req_out_ready)
    );

    l2_msg_fifo #(
        .DEPTH(FIFO_DEPTH),
        .T(l2_rsp_out_t)
    ) rsp_fifo (
        .clk(clk),
        .reset(reset),
        .push(rsp_push),
        .push_data(rsp_msg),
        .full(rsp_full),
        .valid(l2_rsp_out_valid),
        .data(rsp_out),
        .ready(l2_rsp_out_ready)
    );

endmodule

`default_nettype wire

/* verilog/l2_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module l2_ctrl #(
    parameter int SETS = 16
) (
    input  wire logic                    clk,
    input  wire logic                    reset,

    input  wire logic                    cpu_req_valid,
    input  wire l2_pkg::l2_cpu_req_t     cpu_req,
    output logic                         cpu_req_ready,
    input  wire logic                    fwd_in_valid,
    input  wire l2_pkg::l2_fwd_in_t      fwd_in,
    output logic                         fwd_in_ready,
    input  wire logic                    rsp_in_valid,
    input  wire l2_pkg::l2_rsp_in_t      rsp_in,
    output logic                         rsp_in_ready,

    output logic                         rd_rsp_valid,
    output l2_pkg::line_t                rd_rsp_line,
    input  wire logic                    rd_rsp_ready,
    output logic                         inval_valid,
    output l2_pkg::line_addr_t           inval_addr,
    input  wire logic                    inval_ready,

    output logic                         req_push,
    output l2_pkg::l2_req_out_t          req_msg,
    input  wire logic                    req_full,
    output logic                         rsp_push,
    output l2_pkg::l2_rsp_out_t          rsp_msg,
    input  wire logic                    rsp_full,

    output logic [$clog2(SETS)-1:0]      rd_index,
    input  wire l2_pkg::l2_line_entry_t  rd_entry,
    output logic                         wr_en,
    output logic [$clog2(SETS)-1:0]      wr_index,
    output l2_pkg::l2_line_entry_t       wr_entry
);

    import l2_pkg::*;

    localparam int IDX_W = $clog2(SETS);

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        EVICT,
        EVICT_WAIT,
        MISS_REQ,
        MISS_WAIT,
        RESPOND,
        INVAL
    } ctrl_state_t;

    ctrl_state_t state;
    logic is_fwd;
    l2_cpu_req_t cpu_q;
    l2_fwd_in_t fwd_q;
    logic fwd_wr;
    logic fwd_inval;
    // working copy of the line for a victim, a merged hit or a fill
    l2_line_entry_t entry_q;

    line_addr_t cpu_line;
    logic [1:0] word_sel;
    logic tag_hit;
    logic store_busy;

    function automatic line_t merge_word(line_t l, logic [1:0] sel, word_t w);
        line_t merged;
        merged = l;
        merged[sel*WORD_W +: WORD_W] = w;
        return merged;
    endfunction

    assign cpu_line = cpu_q.addr[ADDR_W-1:OFFSET_W];
    assign word_sel = cpu_q.addr[OFFSET_W-1:2];
    assign store_busy = rd_entry.state == L2_BUSY;
    assign tag_hit = rd_entry.state != INVALID &&
                     rd_entry.tag == (is_fwd ? fwd_q.addr : cpu_line);

    // forwards win over cpu requests when idle
    assign fwd_in_ready = state == IDLE && !store_busy;
    assign cpu_req_ready = state == IDLE && !store_busy && !fwd_in_valid && !rd_rsp_valid;
    assign rsp_in_ready = state == EVICT_WAIT || state == MISS_WAIT;

    assign rd_index = fwd_in_valid ? fwd_in.addr[IDX_W-1:0] : cpu_req.addr[OFFSET_W +: IDX_W];

    assign req_push = (state == EVICT || state == MISS_REQ) && !req_full;
    always_comb begin
        req_msg.hprot = cpu_q.hprot;
        if (state == EVICT) begin
            req_msg.coh_msg = REQ_PUTM;
            req_msg.addr = entry_q.tag;
            req_msg.line = entry_q.line;
        end else begin
            if (cpu_q.cpu_msg == WRITE) begin
                req_msg.coh_msg = REQ_GETM;
            end else begin
                req_msg.coh_msg = REQ_GETS;
            end
            req_msg.addr = cpu_line;
            req_msg.line = '0;
        end
    end

    assign rsp_push = state == RESPOND && is_fwd && !rsp_full;
    always_comb begin
        rsp_msg.req_id = fwd_q.req_id;
        rsp_msg.addr = fwd_q.addr;
        rsp_msg.to_req = fwd_q.coh_msg == FWD_GETS ? TO_REQ_HOME : TO_REQ_ONLY;
        if (fwd_q.coh_msg == FWD_INV) begin
            rsp_msg.coh_msg = RSP_INVACK;
            rsp_msg.line = '0;
        end else begin
            rsp_msg.coh_msg = RSP_DATA;
            rsp_msg.line = entry_q.line;
        end
    end

    assign wr_en = state == RESPOND && (is_fwd ? (fwd_wr && !rsp_full) : 1'b1);
    assign wr_index = entry_q.tag[IDX_W-1:0];
    assign wr_entry = entry_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            is_fwd <= 1'b0;
            rd_rsp_valid <= 1'b0;
            inval_valid <= 1'b0;
        end else begin
            if (rd_rsp_valid && rd_rsp_ready) begin
                rd_rsp_valid <= 1'b0;
            end
            if (inval_valid && inval_ready) begin
                inval_valid <= 1'b0;
            end
            case (state)
                IDLE: begin
                    if (fwd_in_valid && fwd_in_ready) begin
                        fwd_q <= fwd_in;
                        is_fwd <= 1'b1;
                        state <= LOOKUP;
                    end else if (cpu_req_valid && cpu_req_ready) begin
                        cpu_q <= cpu_req;
                        is_fwd <= 1'b0;
                        state <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    entry_q <= rd_entry;
                    if (is_fwd) begin
                        fwd_wr <= tag_hit;
                        if (fwd_q.coh_msg == FWD_INV) begin
                            entry_q.state <= INVALID;
                            fwd_inval <= tag_hit;
                            state <= RESPOND;
                        end else if (tag_hit && rd_entry.state == MODIFIED) begin
                            if (fwd_q.coh_msg == FWD_GETS) begin
                                entry_q.state <= SHARED;
                            end else begin
                                entry_q.state <= INVALID;
                            end
                            fwd_inval <= fwd_q.coh_msg == FWD_GETM;
                            state <= RESPOND;
                        end else begin
                            state <= IDLE;
                        end
                    end else if (tag_hit && cpu_q.cpu_msg == READ) begin
                        rd_rsp_valid <= 1'b1;
                        rd_rsp_line <= rd_entry.line;
                        state <= IDLE;
                    end else if (tag_hit && rd_entry.state == MODIFIED) begin
                        entry_q.line <= merge_word(rd_entry.line, word_sel, cpu_q.word);
                        state <= RESPOND;
                    end else if (tag_hit) begin
                        // write to a shared line needs an upgrade
                        state <= MISS_REQ;
                    end else if (rd_entry.state == MODIFIED) begin
                        state <= EVICT;
                    end else if (rd_entry.state == SHARED) begin
                        state <= INVAL;
                    end else begin
                        state <= MISS_REQ;
                    end
                end
                EVICT: begin
                    if (!req_full) begin
                        state <= EVICT_WAIT;
                    end
                end
                EVICT_WAIT: begin
                    if (rsp_in_valid) begin
                        state <= INVAL;
                    end
                end
                MISS_REQ: begin
                    if (!req_full) begin
                        state <= MISS_WAIT;
                    end
                end
                MISS_WAIT: begin
                    if (rsp_in_valid) begin
                        entry_q.tag <= cpu_line;
                        if (cpu_q.cpu_msg == WRITE) begin
                            entry_q.state <= MODIFIED;
                            entry_q.line <= merge_word(rsp_in.line, word_sel, cpu_q.word);
                        end else begin
                            entry_q.state <= SHARED;
                            entry_q.line <= rsp_in.line;
                            rd_rsp_valid <= 1'b1;
                            rd_rsp_line <= rsp_in.line;
                        end
                        state <= RESPOND;
                    end
                end
                RESPOND: begin
                    if (!is_fwd) begin
                        state <= IDLE;
                    end else if (!rsp_full) begin
                        state <= fwd_inval ? INVAL : IDLE;
                    end
                end
                INVAL: begin
                    // tell the L1 the line left once the previous notice is gone
                    if (!inval_valid) begin
                        inval_valid <= 1'b1;
                        inval_addr <= entry_q.tag;
                        state <= is_fwd ? IDLE : MISS_REQ;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // a full queue holds the FSM in place until its message goes in
    assert property (@(posedge clk) disable iff (reset)
        (((state == EVICT || state == MISS_REQ) && !req_push) ||
         (state == RESPOND && is_fwd && !rsp_push)) |=> $stable(state));

    assert property (@(posedge clk) disable iff (reset)
        rd_rsp_valid && !rd_rsp_ready |=> rd_rsp_valid && $stable(rd_rsp_line));

    // home answers must match the transaction that is open
    assert property (@(posedge clk) disable iff (reset)
        rsp_in_valid && rsp_in_ready |->
            (state == MISS_WAIT && rsp_in.coh_msg == RSP_DATA && rsp_in.addr == cpu_line) ||
            (state == EVICT_WAIT && rsp_in.coh_msg == RSP_PUTACK));

endmodule

`default_nettype wire

/* verilog/l2_line_store.sv */
`timescale 1ns/1ps
`default_nettype none

module l2_line_store #(
    parameter int SETS = 16
) (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic [$clog2(SETS)-1:0] rd_index,
    output l2_pkg::l2_line_entry_t       rd_entry,
    input  wire logic                    wr_en,
    input  wire logic [$clog2(SETS)-1:0] wr_index,
    input  wire l2_pkg::l2_line_entry_t  wr_entry
);

    import l2_pkg::*;

    line_addr_t tag_mem [SETS];
    line_t data_mem [SETS];
    l2_state_t state_q [SETS];

    // state bits sit in flops so reset sweeps every set in one cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < SETS; i++) begin
                state_q[i] <= INVALID;
            end
        end else if (wr_en) begin
            state_q[wr_index] <= wr_entry.state;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_index] <= wr_entry.tag;
            data_mem[wr_index] <= wr_entry.line;
        end
    end

    // registered read, busy until the first read after reset
    always_ff @(posedge clk) begin
        rd_entry.tag <= tag_mem[rd_index];
        rd_entry.line <= data_mem[rd_index];
        if (reset) begin
            rd_entry.state <= L2_BUSY;
        end else begin
            rd_entry.state <= state_q[rd_index];
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        rd_entry.state == L2_BUSY |-> !wr_en);

endmodule

`default_nettype wire

/* verilog/l2_msg_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module l2_msg_fifo #(
    parameter int DEPTH = 2,
    parameter type T = logic
) (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic push,
    input  wire T     push_data,
    output logic      full,
    output logic      valid,
    output T          data,
    input  wire logic ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    T mem [DEPTH];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [$clog2(DEPTH+1)-1:0] count;
    logic pop;

    function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] p);
        if (p == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign valid = count != '0;
    assign full = count == DEPTH;
    assign data = mem[head];
    assign pop = valid && ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            head <= '0;
            tail <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail <= next_ptr(tail);
            end
            if (pop) begin
                head <= next_ptr(head);
            end
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[tail] <= push_data;
        end
    end

    assert property (@(posedge clk) disable iff (reset) count <= DEPTH);

endmodule

`default_nettype wire

/* verilog/l2_pkg.sv */
`default_nettype none

package l2_pkg;

    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;
    localparam int WORDS_PER_LINE = 4;
    localparam int OFFSET_W = 4;
    localparam int LINE_ADDR_W = ADDR_W - OFFSET_W;
    localparam int LINE_W = WORD_W * WORDS_PER_LINE;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [WORD_W-1:0] word_t;
    typedef logic [LINE_ADDR_W-1:0] line_addr_t;
    typedef logic [LINE_W-1:0] line_t;
    typedef logic [1:0] cache_id_t;
    typedef logic [0:0] hprot_t;
    typedef logic [1:0] to_req_t;

    // bit 0 goes to the requester, bit 1 to the home
    localparam to_req_t TO_REQ_ONLY = 2'b01;
    localparam to_req_t TO_REQ_HOME = 2'b11;

    typedef enum logic [0:0] {
        READ,
        WRITE
    } cpu_msg_t;

    typedef enum logic [2:0] {
        REQ_GETS,
        REQ_GETM,
        REQ_PUTM,
        RSP_DATA,
        RSP_PUTACK,
        RSP_INVACK
    } coh_msg_t;

    typedef enum logic [1:0] {
        FWD_INV,
        FWD_GETS,
        FWD_GETM
    } mix_msg_t;

    typedef enum logic [1:0] {
        INVALID,
        SHARED,
        MODIFIED
    } l2_state_t;

    // spare encoding, shown by the line store while it comes out of reset
    localparam l2_state_t L2_BUSY = l2_state_t'(2'b11);

    typedef struct packed {
        cpu_msg_t cpu_msg;
        hprot_t   hprot;
        addr_t    addr;
        word_t    word;
    } l2_cpu_req_t;

    typedef struct packed {
        mix_msg_t   coh_msg;
        line_addr_t addr;
        cache_id_t  req_id;
    } l2_fwd_in_t;

    typedef struct packed {
        coh_msg_t   coh_msg;
        line_addr_t addr;
        line_t      line;
    } l2_rsp_in_t;

    typedef struct packed {
        coh_msg_t   coh_msg;
        hprot_t     hprot;
        line_addr_t addr;
        line_t      line;
    } l2_req_out_t;

    typedef struct packed {
        coh_msg_t   coh_msg;
        cache_id_t  req_id;
        to_req_t    to_req;
        line_addr_t addr;
        line_t      line;
    } l2_rsp_out_t;

    typedef struct packed {
        line_addr_t tag;
        l2_state_t  state;
        line_t      line;
    } l2_line_entry_t;

endpackage

`default_nettype wire
